// File: design/agu_stage.sv
`timescale 1ns/1ns
`default_nettype none

`include "lsu_settings.svh"

module agu_stage (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  flush,
    input  logic                  uop_valid,
    input  lsu_pkg::uop_t         uop,
    input  logic                  ale_en,
    input  logic                  data_addr_ok,
    input  logic                  ms_allowin,
    output logic                  uop_allowin,
    output logic                  data_req,
    output lsu_pkg::sram_req_t    data_wr_req,
    output logic                  es_valid,
    output lsu_pkg::es_to_ms_t    es_payload,
    output logic                  es_issued
);

    lsu_pkg::uop_t          op;
    logic                   held_valid;
    logic                   issued;
    logic                   mem_access;
    logic                   need_req;
    logic                   req_done;
    logic                   ready_go;
    logic                   misaligned;
    logic                   ale;
    logic [1:0]             size;
    logic [3:0]             strb;
    logic [`LSU_ADDR_W-1:0] raw_addr;
    logic [`LSU_ADDR_W-1:0] aligned_addr;
    logic [`LSU_ADDR_W-1:0] eff_addr;

    stage_reg #(
        .payload_t(lsu_pkg::uop_t)
    ) slot (
        .clk              (clk),
        .reset            (reset),
        .flush            (flush),
        .in_valid         (uop_valid),
        .in_payload       (uop),
        .ready_go         (ready_go),
        .out_allowin_next (ms_allowin),
        .allowin          (uop_allowin),
        .out_valid        (held_valid),
        .out_payload      (op)
    );

    assign raw_addr = op.base + {{(`LSU_ADDR_W-12){op.offset[11]}}, op.offset};

    always_comb begin
        size = op.st_size;
        if (op.is_load) begin
            case (op.ld_op)
                lsu_pkg::LD_B, lsu_pkg::LD_BU: size = 2'd0;
                lsu_pkg::LD_H, lsu_pkg::LD_HU: size = 2'd1;
                default:                       size = 2'd2;
            endcase
        end
    end

    assign misaligned = (size == 2'd1) ? raw_addr[0] :
                        (size == 2'd2) ? |raw_addr[1:0] : 1'b0;
    assign aligned_addr = (size == 2'd1) ? {raw_addr[`LSU_ADDR_W-1:1], 1'b0} :
                          (size == 2'd2) ? {raw_addr[`LSU_ADDR_W-1:2], 2'b00} : raw_addr;

    assign mem_access = op.is_load || op.is_store;
    assign ale        = mem_access && misaligned && ale_en;
    // faulting ops keep the raw address for badv
    assign eff_addr   = ale ? raw_addr : aligned_addr;

    always_comb begin
        case (size)
            2'd0:    strb = 4'b0001 << eff_addr[1:0];
            2'd1:    strb = 4'b0011 << {eff_addr[1], 1'b0};
            default: strb = 4'b1111;
        endcase
    end

    assign need_req = mem_access && !ale;
    assign data_req = held_valid && need_req && !issued && !flush;
    assign req_done = issued || (data_req && data_addr_ok);
    assign ready_go = !need_req || req_done;

    assign data_wr_req.wr    = op.is_store;
    assign data_wr_req.size  = size;
    assign data_wr_req.wstrb = op.is_store ? strb : 4'b0000;
    assign data_wr_req.addr  = eff_addr;
    assign data_wr_req.wdata = op.store_data << {eff_addr[1:0], 3'b000};

    // request accepted but op still waiting on mem_stage
    always_ff @(posedge clk) begin
        if (reset) begin
            issued <= 1'b0;
        end else if (flush) begin
            issued <= 1'b0;
        end else if (es_valid && ms_allowin) begin
            issued <= 1'b0;
        end else if (data_req && data_addr_ok) begin
            issued <= 1'b1;
        end
    end

    assign es_valid  = held_valid && ready_go;
    assign es_issued = req_done;

    assign es_payload.pc         = op.pc;
    assign es_payload.addr       = eff_addr;
    assign es_payload.is_load    = op.is_load;
    assign es_payload.mem_access = mem_access;
    assign es_payload.ld_op      = op.ld_op;
    assign es_payload.dest       = op.dest;
    assign es_payload.ale        = ale;

endmodule

`default_nettype wire

// File: design/except_csr.sv
`timescale 1ns/1ns
`default_nettype none

`include "lsu_settings.svh"

module except_csr (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   exc_valid,
    input  logic [`LSU_ADDR_W-1:0] exc_pc,
    input  logic [`LSU_ADDR_W-1:0] exc_addr,
    input  logic                   wb_cyc,
    input  logic                   wb_stb,
    input  logic                   wb_we,
    input  logic [1:0]             wb_adr,
    input  logic [`LSU_ADDR_W-1:0] wb_dat_w,
    input  logic [3:0]             wb_sel,
    output logic [`LSU_ADDR_W-1:0] wb_dat_r,
    output logic                   wb_ack,
    output logic                   ale_en,
    output logic                   flush
);

    logic                   cause_valid;
    logic [5:0]             cause_code;
    logic [`LSU_ADDR_W-1:0] badv;
    logic [`LSU_ADDR_W-1:0] era;
    logic                   wb_req;
    logic                   exc_take;
    logic                   clear_valid;

    assign wb_req      = wb_cyc && wb_stb && !wb_ack;
    assign exc_take    = exc_valid && !cause_valid;
    // cause valid sits in bit 31, write one to clear
    assign clear_valid = wb_req && wb_we && (wb_adr == `CSR_CAUSE) && wb_sel[3]
                         && wb_dat_w[31];

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_ack      <= 1'b0;
            ale_en      <= 1'b1;
            cause_valid <= 1'b0;
            cause_code  <= 6'd0;
            flush       <= 1'b0;
        end else begin
            wb_ack <= wb_req;
            // pulse on commit, then every other cycle until cleared
            flush  <= !flush && (exc_take || (cause_valid && !clear_valid));
            if (wb_req && wb_we && (wb_adr == `CSR_CTRL) && wb_sel[0]) begin
                ale_en <= wb_dat_w[0];
            end
            if (exc_take) begin
                cause_valid <= 1'b1;
                cause_code  <= `EXC_ALE;
            end else if (clear_valid) begin
                cause_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (exc_take) begin
            badv <= exc_addr;
            era  <= exc_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (wb_req) begin
            case (wb_adr)
                `CSR_CTRL:  wb_dat_r <= {{(`LSU_ADDR_W-1){1'b0}}, ale_en};
                `CSR_CAUSE: wb_dat_r <= {cause_valid, {(`LSU_ADDR_W-7){1'b0}}, cause_code};
                `CSR_BADV:  wb_dat_r <= badv;
                default:    wb_dat_r <= era;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/lsu_pkg.sv
`default_nettype none

`include "lsu_settings.svh"

package lsu_pkg;

    typedef enum logic [2:0] {
        LD_B  = 3'd0,
        LD_BU = 3'd1,
        LD_H  = 3'd2,
        LD_HU = 3'd3,
        LD_W  = 3'd4
    } ld_op_e;

    // st_size holds log2 of the byte count
    typedef struct packed {
        logic [`LSU_ADDR_W-1:0] pc;
        logic                   is_load;
        logic                   is_store;
        ld_op_e                 ld_op;
        logic [1:0]             st_size;
        logic [`LSU_ADDR_W-1:0] base;
        logic [11:0]            offset;
        logic [`LSU_ADDR_W-1:0] store_data;
        logic [4:0]             dest;
    } uop_t;

    typedef struct packed {
        logic [`LSU_ADDR_W-1:0] pc;
        logic [`LSU_ADDR_W-1:0] addr;
        logic                   is_load;
        logic                   mem_access;
        ld_op_e                 ld_op;
        logic [4:0]             dest;
        logic                   ale;
    } es_to_ms_t;

    typedef struct packed {
        logic [`LSU_ADDR_W-1:0] pc;
        logic [`LSU_ADDR_W-1:0] addr;
        logic                   gr_we;
        logic [4:0]             dest;
        logic [`LSU_ADDR_W-1:0] result;
        logic                   ale;
    } ms_to_ws_t;

    typedef struct packed {
        logic                   wr;
        logic [1:0]             size;
        logic [3:0]             wstrb;
        logic [`LSU_ADDR_W-1:0] addr;
        logic [`LSU_ADDR_W-1:0] wdata;
    } sram_req_t;

    typedef struct packed {
        logic [`LSU_ADDR_W-1:0] pc;
        logic                   rf_we;
        logic [4:0]             rf_waddr;
        logic [`LSU_ADDR_W-1:0] rf_wdata;
    } retire_t;

endpackage

`default_nettype wire

// File: design/lsu_settings.svh
`ifndef LSU_SETTINGS_SVH
`define LSU_SETTINGS_SVH

// address and data width
`define LSU_ADDR_W 32

// wishbone word offsets of the status registers
`define CSR_CTRL  2'd0
`define CSR_CAUSE 2'd1
`define CSR_BADV  2'd2
`define CSR_ERA   2'd3

// address misaligned
`define EXC_ALE 6'h09

`endif

// File: design/lsu_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "lsu_settings.svh"

module lsu_top (
    input  logic                   clk,
    input  logic                   reset,
    // upstream issue port
    input  logic                   uop_valid,
    input  lsu_pkg::uop_t          uop,
    output logic                   uop_allowin,
    // data sram port
    output logic                   data_req,
    output lsu_pkg::sram_req_t     data_wr_req,
    input  logic                   data_addr_ok,
    input  logic                   data_ok,
    input  logic [`LSU_ADDR_W-1:0] data_rdata,
    output lsu_pkg::retire_t       retire,
    // status register bus
    input  logic                   wb_cyc,
    input  logic                   wb_stb,
    input  logic                   wb_we,
    input  logic [1:0]             wb_adr,
    input  logic [`LSU_ADDR_W-1:0] wb_dat_w,
    input  logic [3:0]             wb_sel,
    output logic [`LSU_ADDR_W-1:0] wb_dat_r,
    output logic                   wb_ack
);

    logic                   flush;
    logic                   ale_en;
    logic                   es_valid;
    logic                   es_issued;
    lsu_pkg::es_to_ms_t     es_payload;
    logic                   ms_allowin;
    logic                   ms_valid;
    lsu_pkg::ms_to_ws_t     ms_payload;
    logic                   ws_allowin;
    logic                   exc_valid;
    logic [`LSU_ADDR_W-1:0] exc_pc;
    logic [`LSU_ADDR_W-1:0] exc_addr;

    agu_stage agu_stage_inst (
        .clk          (clk),
        .reset        (reset),
        .flush        (flush),
        .uop_valid    (uop_valid),
        .uop          (uop),
        .ale_en       (ale_en),
        .data_addr_ok (data_addr_ok),
        .ms_allowin   (ms_allowin),
        .uop_allowin  (uop_allowin),
        .data_req     (data_req),
        .data_wr_req  (data_wr_req),
        .es_valid     (es_valid),
        .es_payload   (es_payload),
        .es_issued    (es_issued)
    );

    mem_stage mem_stage_inst (
        .clk        (clk),
        .reset      (reset),
        .flush      (flush),
        .es_valid   (es_valid),
        .es_payload (es_payload),
        .es_issued  (es_issued),
        .ws_allowin (ws_allowin),
        .data_ok    (data_ok),
        .data_rdata (data_rdata),
        .ms_allowin (ms_allowin),
        .ms_valid   (ms_valid),
        .ms_payload (ms_payload)
    );

    wb_stage wb_stage_inst (
        .clk        (clk),
        .reset      (reset),
        .flush      (flush),
        .ms_valid   (ms_valid),
        .ms_payload (ms_payload),
        .ws_allowin (ws_allowin),
        .retire     (retire),
        .exc_valid  (exc_valid),
        .exc_pc     (exc_pc),
        .exc_addr   (exc_addr)
    );

    except_csr except_csr_inst (
        .clk       (clk),
        .reset     (reset),
        .exc_valid (exc_valid),
        .exc_pc    (exc_pc),
        .exc_addr  (exc_addr),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .wb_sel    (wb_sel),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack),
        .ale_en    (ale_en),
        .flush     (flush)
    );

endmodule

`default_nettype wire

// File: design/mem_stage.sv
`timescale 1ns/1ns
`default_nettype none

`include "lsu_settings.svh"

module mem_stage (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   flush,
    input  logic                   es_valid,
    input  lsu_pkg::es_to_ms_t     es_payload,
    input  logic                   es_issued,
    input  logic                   ws_allowin,
    input  logic                   data_ok,
    input  logic [`LSU_ADDR_W-1:0] data_rdata,
    output logic                   ms_allowin,
    output logic                   ms_valid,
    output lsu_pkg::ms_to_ws_t     ms_payload
);

    lsu_pkg::es_to_ms_t     p;
    logic                   held_valid;
    logic                   need_mem;
    logic                   ready_go;
    logic [2:0]             drop_cnt;
    logic                   discard;
    logic                   ok_drop;
    logic                   ok_own;
    logic                   ms_pending;
    logic [`LSU_ADDR_W-1:0] lane;
    logic [`LSU_ADDR_W-1:0] ld_result;

    stage_reg #(
        .payload_t(lsu_pkg::es_to_ms_t)
    ) slot (
        .clk              (clk),
        .reset            (reset),
        .flush            (flush),
        .in_valid         (es_valid),
        .in_payload       (es_payload),
        .ready_go         (ready_go),
        .out_allowin_next (ws_allowin),
        .allowin          (ms_allowin),
        .out_valid        (held_valid),
        .out_payload      (p)
    );

    // responses owed to flushed ops come first, in order
    assign discard    = drop_cnt != 3'd0;
    assign ok_drop    = data_ok && discard;
    assign ok_own     = data_ok && !discard;
    assign need_mem   = p.mem_access && !p.ale;
    assign ms_pending = held_valid && need_mem && !ok_own;

    assign ready_go = !need_mem || ok_own;
    assign ms_valid = held_valid && ready_go;

    always_ff @(posedge clk) begin
        if (reset) begin
            drop_cnt <= 3'd0;
        end else if (flush) begin
            drop_cnt <= drop_cnt - {2'b00, ok_drop} + {2'b00, es_issued}
                        + {2'b00, ms_pending};
        end else begin
            drop_cnt <= drop_cnt - {2'b00, ok_drop};
        end
    end

    // halves are aligned here, so one shift covers both widths
    assign lane = data_rdata >> {p.addr[1:0], 3'b000};

    always_comb begin
        case (p.ld_op)
            lsu_pkg::LD_B:  ld_result = {{(`LSU_ADDR_W-8){lane[7]}}, lane[7:0]};
            lsu_pkg::LD_BU: ld_result = {{(`LSU_ADDR_W-8){1'b0}}, lane[7:0]};
            lsu_pkg::LD_H:  ld_result = {{(`LSU_ADDR_W-16){lane[15]}}, lane[15:0]};
            lsu_pkg::LD_HU: ld_result = {{(`LSU_ADDR_W-16){1'b0}}, lane[15:0]};
            default:        ld_result = data_rdata;
        endcase
    end

    assign ms_payload.pc     = p.pc;
    assign ms_payload.addr   = p.addr;
    assign ms_payload.gr_we  = p.is_load && !p.ale;
    assign ms_payload.dest   = p.dest;
    assign ms_payload.result = ld_result;
    assign ms_payload.ale    = p.ale;

endmodule

`default_nettype wire

// File: design/stage_reg.sv
`timescale 1ns/1ns
`default_nettype none

module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     flush,
    input  logic     in_valid,
    input  payload_t in_payload,
    input  logic     ready_go,
    input  logic     out_allowin_next,
    output logic     allowin,
    output logic     out_valid,
    output payload_t out_payload
);

    logic valid;

    // empty, or leaving this cycle
    assign allowin   = !valid || (ready_go && out_allowin_next);
    assign out_valid = valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= 1'b0;
        end else if (flush) begin
            valid <= 1'b0;
        end else if (allowin) begin
            valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && allowin) begin
            out_payload <= in_payload;
        end
    end

endmodule

`default_nettype wire

// File: design/wb_stage.sv
`timescale 1ns/1ns
`default_nettype none

`include "lsu_settings.svh"

module wb_stage (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   flush,
    input  logic                   ms_valid,
    input  lsu_pkg::ms_to_ws_t     ms_payload,
    output logic                   ws_allowin,
    output lsu_pkg::retire_t       retire,
    output logic                   exc_valid,
    output logic [`LSU_ADDR_W-1:0] exc_pc,
    output logic [`LSU_ADDR_W-1:0] exc_addr
);

    lsu_pkg::ms_to_ws_t p;
    logic               held_valid;

    // last stage never stalls
    stage_reg #(
        .payload_t(lsu_pkg::ms_to_ws_t)
    ) slot (
        .clk              (clk),
        .reset            (reset),
        .flush            (flush),
        .in_valid         (ms_valid),
        .in_payload       (ms_payload),
        .ready_go         (1'b1),
        .out_allowin_next (1'b1),
        .allowin          (ws_allowin),
        .out_valid        (held_valid),
        .out_payload      (p)
    );

    // the op behind a faulting one sits here while flush is high
    assign retire.pc       = p.pc;
    assign retire.rf_we    = held_valid && !p.ale && p.gr_we && !flush;
    assign retire.rf_waddr = p.dest;
    assign retire.rf_wdata = p.result;

    assign exc_valid = held_valid && p.ale;
    assign exc_pc    = p.pc;
    assign exc_addr  = p.addr;

endmodule

`default_nettype wire

// File: lsu_top.f
+incdir+design
design/lsu_pkg.sv
design/stage_reg.sv
design/agu_stage.sv
design/mem_stage.sv
design/wb_stage.sv
design/except_csr.sv
design/lsu_top.sv
tests/lsu_props.sv
tests/lsu_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the lsu testbench with verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -f lsu_top.f --top-module lsu_tb \
        --Mdir obj_dir -o lsu_sim > build.log 2>&1; then
    echo "verilator build failed, see build.log"
    exit 1
fi

if ! ./obj_dir/lsu_sim > sim.log 2>&1; then
    echo "simulation exited with an error, see sim.log"
    exit 1
fi

if grep -q "^RESULT: PASS$" sim.log; then
    echo "simulation passed"
    exit 0
fi

echo "simulation failed, see sim.log"
exit 1

// File: tests/lsu_props.sv
`timescale 1ns/1ns
`default_nettype none

module lsu_props (
    input wire logic               clk,
    input wire logic               reset,
    input wire logic               data_req,
    input wire logic               data_addr_ok,
    input wire lsu_pkg::sram_req_t data_wr_req,
    input wire logic               flush,
    input wire logic               exc_valid,
    input wire logic               wb_stb,
    input wire logic               wb_ack
);

    // a waiting request only goes away on flush
    req_held: assert property (@(posedge clk) disable iff (reset)
        data_req && !data_addr_ok |=> (flush || data_req) && $stable(data_wr_req))
        else $error("request changed while waiting for addr_ok");

    // one flush pulse in the cycle after a new exception
    flush_after_exc: assert property (@(posedge clk) disable iff (reset)
        exc_valid && !flush |=> flush ##1 !flush)
        else $error("exception not followed by a single flush pulse");

    ack_needs_stb: assert property (@(posedge clk) disable iff (reset)
        wb_ack |-> wb_stb)
        else $error("wb_ack without wb_stb");

endmodule

bind lsu_top lsu_props lsu_props_inst (
    .clk          (clk),
    .reset        (reset),
    .data_req     (data_req),
    .data_addr_ok (data_addr_ok),
    .data_wr_req  (data_wr_req),
    .flush        (flush),
    .exc_valid    (exc_valid),
    .wb_stb       (wb_stb),
    .wb_ack       (wb_ack)
);

`default_nettype wire

// File: tests/lsu_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "lsu_settings.svh"

module lsu_tb;

    logic                   clk;
    logic                   reset;
    logic                   uop_valid;
    lsu_pkg::uop_t          uop;
    logic                   uop_allowin;
    logic                   data_req;
    lsu_pkg::sram_req_t     data_wr_req;
    logic                   data_addr_ok;
    logic                   data_ok;
    logic [`LSU_ADDR_W-1:0] data_rdata;
    lsu_pkg::retire_t       retire;
    logic                   wb_cyc;
    logic                   wb_stb;
    logic                   wb_we;
    logic [1:0]             wb_adr;
    logic [`LSU_ADDR_W-1:0] wb_dat_w;
    logic [3:0]             wb_sel;
    logic [`LSU_ADDR_W-1:0] wb_dat_r;
    logic                   wb_ack;

    logic [31:0] t_kind [0:63];
    logic [31:0] t_pc   [0:63];
    logic [31:0] t_base [0:63];
    logic [31:0] t_off  [0:63];
    logic [31:0] t_ldop [0:63];
    logic [31:0] t_size [0:63];
    logic [31:0] t_sdata[0:63];
    logic [31:0] t_dest [0:63];
    logic [31:0] t_expa [0:63];
    logic [31:0] t_expb [0:63];
    logic [31:0] f      [0:9];
    int          n_lines;
    logic        loaded;

    logic [31:0] mem [0:255];
    logic [31:0] lfsr;
    logic [31:0] resp_data[$];
    int          resp_ready[$];
    int          cycle;
    logic [31:0] addr_wait;

    logic [31:0] exp_pc[$];
    logic [31:0] exp_data[$];
    logic [4:0]  exp_dest[$];
    logic [1:0]  exp_st_size[$];
    logic        exc_seen;
    int          errors;
    int          n_checks;
    int          fd;
    int          n;
    int          exc_idx;
    logic        exc_pending;
    logic [31:0] rd;
    string       line;

    lsu_top lsu_top_inst (
        .clk          (clk),
        .reset        (reset),
        .uop_valid    (uop_valid),
        .uop          (uop),
        .uop_allowin  (uop_allowin),
        .data_req     (data_req),
        .data_wr_req  (data_wr_req),
        .data_addr_ok (data_addr_ok),
        .data_ok      (data_ok),
        .data_rdata   (data_rdata),
        .retire       (retire),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_dat_w     (wb_dat_w),
        .wb_sel       (wb_sel),
        .wb_dat_r     (wb_dat_r),
        .wb_ack       (wb_ack)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] next_lfsr(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] draw(input int bits);
        logic [31:0] v;
        v = 32'd0;
        for (int i = 0; i < bits; i++) begin
            lfsr = next_lfsr(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            $display("FAIL %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    // sram model with one acceptance per cycle and in-order responses
    initial begin
        wait (loaded);
        forever begin
            @(negedge clk);
            cycle++;
            data_ok = resp_data.size() != 0 && resp_ready[0] <= cycle;
            data_rdata = data_ok ? resp_data[0] : 32'd0;
            data_addr_ok = addr_wait == 32'd0;
            #8;
            if (data_ok) begin
                void'(resp_data.pop_front());
                void'(resp_ready.pop_front());
            end
            if (data_req && data_addr_ok) begin
                if (data_wr_req.wr) begin
                    if (exp_st_size.size() == 0) begin
                        $display("store request arrived with no store pending");
                        errors++;
                    end else begin
                        check("data_wr_req.size", {30'd0, data_wr_req.size},
                              {30'd0, exp_st_size.pop_front()});
                    end
                end
                resp_data.push_back(data_wr_req.wr ? 32'd0 : mem[data_wr_req.addr[9:2]]);
                for (int b = 0; b < 4; b++) begin
                    if (data_wr_req.wstrb[b]) begin
                        mem[data_wr_req.addr[9:2]][b*8 +: 8] = data_wr_req.wdata[b*8 +: 8];
                    end
                end
                resp_ready.push_back(cycle + 1 + int'(draw(2)));
                addr_wait = draw(2);
            end else if (data_req) begin
                addr_wait = addr_wait - 32'd1;
            end
        end
    end

    // retire and flush monitor
    initial begin
        forever begin
            @(negedge clk);
            #8;
            if (!reset && lsu_top_inst.flush) begin
                exc_seen = 1'b1;
            end
            if (!reset && retire.rf_we) begin
                if (exp_pc.size() == 0) begin
                    $display("unexpected retire with nothing pending, pc %h", retire.pc);
                    errors++;
                end else begin
                    check("retire.pc", retire.pc, exp_pc.pop_front());
                    check("retire.rf_waddr", {27'd0, retire.rf_waddr}, {27'd0, exp_dest[0]});
                    void'(exp_dest.pop_front());
                    check("retire.rf_wdata", retire.rf_wdata, exp_data.pop_front());
                end
            end
        end
    end

    initial begin
        wait (loaded);
        repeat (n_lines * 40) @(posedge clk);
        $display("timeout, the trace did not finish in %0d cycles", n_lines * 40);
        $display("RESULT: FAIL");
        $finish;
    end

    function automatic lsu_pkg::uop_t make_uop(input int i);
        lsu_pkg::uop_t u;
        u.pc         = t_pc[i];
        u.is_load    = t_kind[i] != 32'd1;
        u.is_store   = t_kind[i] == 32'd1;
        u.ld_op      = lsu_pkg::ld_op_e'(t_ldop[i][2:0]);
        u.st_size    = t_size[i][1:0];
        u.base       = t_base[i];
        u.offset     = t_off[i][11:0];
        u.store_data = t_sdata[i];
        u.dest       = t_dest[i][4:0];
        return u;
    endfunction

    // called at a falling edge, returns at the falling edge after acceptance
    task automatic send_uop(input lsu_pkg::uop_t u);
        logic acc;
        uop_valid = 1'b1;
        uop = u;
        do begin
            #8;
            acc = uop_allowin;
            @(negedge clk);
        end while (!acc);
        uop_valid = 1'b0;
    endtask

    task automatic wb_access(input logic we, input logic [1:0] adr, input logic [31:0] wdat,
                             output logic [31:0] rdat);
        logic got;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we = we;
        wb_adr = adr;
        wb_dat_w = wdat;
        wb_sel = 4'hf;
        rdat = 32'd0;
        do begin
            #8;
            got = wb_ack;
            if (got) begin
                rdat = wb_dat_r;
            end
            @(negedge clk);
        end while (!got);
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
    endtask

    task automatic handle_exception(input int i);
        logic [31:0] r;
        while (!exc_seen) @(negedge clk);
        wb_access(1'b0, `CSR_CAUSE, 32'd0, r);
        check("cause.code", {26'd0, r[5:0]}, t_expa[i]);
        check("cause.valid", {31'd0, r[31]}, 32'd1);
        wb_access(1'b0, `CSR_BADV, 32'd0, r);
        check("badv", r, t_expb[i]);
        wb_access(1'b0, `CSR_ERA, 32'd0, r);
        check("era", r, t_pc[i]);
        wb_access(1'b1, `CSR_CAUSE, 32'h8000_0000, r);
        wb_access(1'b0, `CSR_CAUSE, 32'd0, r);
        check("cause.valid", {31'd0, r[31]}, 32'd0);
        exc_seen = 1'b0;
    endtask

    initial begin
        reset = 1'b1;
        uop_valid = 1'b0;
        uop = '0;
        data_addr_ok = 1'b0;
        data_ok = 1'b0;
        data_rdata = 32'd0;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = 2'd0;
        wb_dat_w = 32'd0;
        wb_sel = 4'd0;
        lfsr = 32'hb014b5c8;
        cycle = 0;
        addr_wait = 32'd0;
        exc_seen = 1'b0;
        exc_pending = 1'b0;
        exc_idx = 0;
        errors = 0;
        n_checks = 0;
        n_lines = 0;
        loaded = 1'b0;
        for (int i = 0; i < 256; i++) begin
            mem[i] = i * 32'h0101_0101 + 32'h0011_2233;
        end

        fd = $fopen("tests/lsu_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open the trace file tests/lsu_trace.txt");
            errors++;
        end else begin
            while (!$feof(fd) && n_lines < 64) begin
                n = $fgets(line, fd);
                if (n > 1 && line[0] != "#") begin
                    n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h",
                                f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9]);
                    if (n == 10) begin
                        t_kind[n_lines]  = f[0];
                        t_pc[n_lines]    = f[1];
                        t_base[n_lines]  = f[2];
                        t_off[n_lines]   = f[3];
                        t_ldop[n_lines]  = f[4];
                        t_size[n_lines]  = f[5];
                        t_sdata[n_lines] = f[6];
                        t_dest[n_lines]  = f[7];
                        t_expa[n_lines]  = f[8];
                        t_expb[n_lines]  = f[9];
                        n_lines++;
                    end
                end
            end
            $fclose(fd);
        end
        loaded = 1'b1;

        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        check("uop_allowin", {31'd0, uop_allowin}, 32'd1);
        check("data_req", {31'd0, data_req}, 32'd0);
        check("retire.rf_we", {31'd0, retire.rf_we}, 32'd0);
        check("flush", {31'd0, lsu_top_inst.flush}, 32'd0);
        check("wb_ack", {31'd0, wb_ack}, 32'd0);

        for (int i = 0; i < n_lines; i++) begin
            if (exc_pending && t_kind[i] != 32'd4) begin
                handle_exception(exc_idx);
                exc_pending = 1'b0;
            end
            repeat (int'(draw(1))) @(negedge clk);
            case (t_kind[i])
                32'd0: begin
                    exp_pc.push_back(t_pc[i]);
                    exp_data.push_back(t_expa[i]);
                    exp_dest.push_back(t_dest[i][4:0]);
                    send_uop(make_uop(i));
                end
                32'd1: begin
                    exp_st_size.push_back(t_size[i][1:0]);
                    send_uop(make_uop(i));
                end
                32'd2: begin
                    while (exp_pc.size() != 0 || data_req) @(negedge clk);
                    repeat (4) @(negedge clk);
                    wb_access(1'b1, `CSR_CTRL, t_expa[i], rd);
                    wb_access(1'b0, `CSR_CTRL, 32'd0, rd);
                    check("ctrl", {31'd0, rd[0]}, t_expa[i]);
                end
                32'd3: begin
                    exc_pending = 1'b1;
                    exc_idx = i;
                    send_uop(make_uop(i));
                end
                default: begin
                    send_uop(make_uop(i));
                end
            endcase
        end
        if (exc_pending) begin
            handle_exception(exc_idx);
        end
        while (exp_pc.size() != 0) @(negedge clk);
        repeat (10) @(negedge clk);

        $display("checks %0d errors %0d", n_checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tests/lsu_trace.txt
# kind pc base offset ld_op st_size store_data dest exp_a exp_b, all hex
# kind 0 load, 1 store, 2 ctrl write, 3 faulting load, 4 load lost to flush
0 1c000000 00000180 000 4 0 00000000 01 60718293 00000000
0 1c000004 00000100 080 0 0 00000000 02 ffffff93 00000000
0 1c000008 00000180 001 0 0 00000000 03 ffffff82 00000000
0 1c00000c 00000180 002 0 0 00000000 04 00000071 00000000
0 1c000010 00000180 003 0 0 00000000 05 00000060 00000000
0 1c000014 00000180 000 1 0 00000000 06 00000093 00000000
0 1c000018 00000180 001 1 0 00000000 07 00000082 00000000
0 1c00001c 00000180 000 2 0 00000000 08 ffff8293 00000000
0 1c000020 00000180 002 2 0 00000000 09 00006071 00000000
0 1c000024 00000180 000 3 0 00000000 0a 00008293 00000000
0 1c000028 00000180 002 3 0 00000000 0b 00006071 00000000
0 1c00002c 00000200 040 4 0 00000000 0c 90a1b2c3 00000000
0 1c000030 00000200 043 0 0 00000000 0d ffffff90 00000000
0 1c000034 00000200 042 3 0 00000000 0e 000090a1 00000000
1 1c000038 00000200 041 0 0 000000ab 00 00000000 00000000
0 1c00003c 00000200 040 4 0 00000000 0f 90a1abc3 00000000
1 1c000040 00000280 002 0 1 0000beef 00 00000000 00000000
0 1c000044 00000280 000 4 0 00000000 10 beefc2d3 00000000
0 1c000048 00000300 f82 2 0 00000000 11 ffffbeef 00000000
3 1c00004c 00000180 001 4 0 00000000 1f 00000009 00000181
4 1c000050 00000180 000 4 0 00000000 1e 00000000 00000000
4 1c000054 00000180 004 2 0 00000000 1d 00000000 00000000
0 1c000058 00000180 000 4 0 00000000 12 60718293 00000000
0 1c00005c 00000180 006 2 0 00000000 13 00006172 00000000
2 1c000060 00000000 000 0 0 00000000 00 00000000 00000000
0 1c000064 00000100 005 4 0 00000000 14 41526374 00000000
0 1c000068 00000100 003 2 0 00000000 15 00004051 00000000
